// ==== Makefile ====
# Verilator build and run for the branch prediction front end

VERILATOR ?= verilator
TOP       ?= bpred_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard design/*.sv sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "Simulation completed successfully" $(LOG) || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/bpred_top.sv ====
/*
 * branch prediction front end
 * fetch PC, BTB and execute-stage resolver wired together
 */
`timescale 1ns/1ns
`default_nettype none

module bpred_top #(
   parameter int                   BTB_ENTRIES = 4,
   parameter cpu_types_pkg::word_t RESET_PC    = '0
) (
   input  wire logic                  CLK,
   input  wire logic                  nRST,
   input  wire logic                  stall,
   input  wire logic                  ex_valid,
   input  wire cpu_types_pkg::word_t  ex_pc,
   input  wire cpu_types_pkg::instr_t ex_instr,
   input  wire cpu_types_pkg::word_t  ex_rs_data,
   input  wire cpu_types_pkg::word_t  ex_rt_data,
   input  wire logic                  ex_pred_taken,
   input  wire cpu_types_pkg::word_t  ex_pred_target,
   output cpu_types_pkg::word_t       pc,
   output logic                       pred_taken,
   output cpu_types_pkg::word_t       pred_target,
   output logic                       flush,
   output cpu_types_pkg::word_t       redirect_pc
);
   import cpu_types_pkg::*;

   logic  btb_hit;
   // resolver to BTB write port
   logic  upd_wen;
   word_t upd_pc;
   logic  upd_taken;
   word_t upd_target;

   fetch_pc #(
      .RESET_PC (RESET_PC)
   ) fetch0 (
      .CLK         (CLK),
      .nRST        (nRST),
      .stall       (stall),
      .flush       (flush),
      .redirect_pc (redirect_pc),
      .btb_hit     (btb_hit),
      .btb_taken   (pred_taken),
      .btb_target  (pred_target),
      .pc          (pc)
   );

   btb #(
      .BTB_ENTRIES (BTB_ENTRIES)
   ) btb0 (
      .CLK         (CLK),
      .nRST        (nRST),
      .rd_pc       (pc),
      .wr_en       (upd_wen),
      .wr_pc       (upd_pc),
      .wr_taken    (upd_taken),
      .wr_target   (upd_target),
      .hit         (btb_hit),
      .pred_taken  (pred_taken),
      .pred_target (pred_target)
   );

   branch_resolve resolve0 (
      .CLK            (CLK),
      .nRST           (nRST),
      .ex_valid       (ex_valid),
      .ex_pc          (ex_pc),
      .ex_instr       (ex_instr),
      .ex_rs_data     (ex_rs_data),
      .ex_rt_data     (ex_rt_data),
      .ex_pred_taken  (ex_pred_taken),
      .ex_pred_target (ex_pred_target),
      .flush          (flush),
      .redirect_pc    (redirect_pc),
      .upd_wen        (upd_wen),
      .upd_pc         (upd_pc),
      .upd_taken      (upd_taken),
      .upd_target     (upd_target)
   );

endmodule

`default_nettype wire

// ==== design/branch_resolve.sv ====
/*
 * branch resolver
 * resolves BEQ, BNE and J in execute, checks the carried prediction
 * and issues a one-cycle flush, redirect and BTB update
 */
`timescale 1ns/1ns
`default_nettype none

module branch_resolve (
   input  wire logic                    CLK,
   input  wire logic                    nRST,
   input  wire logic                    ex_valid,
   input  wire cpu_types_pkg::word_t    ex_pc,
   input  wire cpu_types_pkg::instr_t   ex_instr,
   input  wire cpu_types_pkg::word_t    ex_rs_data,
   input  wire cpu_types_pkg::word_t    ex_rt_data,
   input  wire logic                    ex_pred_taken,
   input  wire cpu_types_pkg::word_t    ex_pred_target,
   output logic                         flush,
   output cpu_types_pkg::word_t         redirect_pc,
   output logic                         upd_wen,
   output cpu_types_pkg::word_t         upd_pc,
   output logic                         upd_taken,
   output cpu_types_pkg::word_t         upd_target
);
   import cpu_types_pkg::*;

   word_t pc_plus4;
   word_t br_target;
   word_t j_target;
   word_t act_target;
   logic  is_beq;
   logic  is_bne;
   logic  is_j;
   logic  is_ctrl;
   logic  operands_eq;
   logic  act_taken;
   logic  mispred;
   logic  resolve;

   // decode, branch fields through the I view and jump fields through the J view
   assign is_beq  = (ex_instr.i.opcode == BEQ);
   assign is_bne  = (ex_instr.i.opcode == BNE);
   assign is_j    = (ex_instr.j.opcode == J);
   assign is_ctrl = is_beq || is_bne || is_j;
   assign resolve = ex_valid && is_ctrl;

   assign pc_plus4  = ex_pc + 32'd4;
   assign br_target = pc_plus4 + {{14{ex_instr.i.imm[15]}}, ex_instr.i.imm, 2'b00};
   // region of the delay slot address, plus the word address
   assign j_target  = {pc_plus4[31:28], ex_instr.j.addr, 2'b00};

   assign operands_eq = (ex_rs_data == ex_rt_data);
   assign act_taken   = is_j || (is_beq && operands_eq) || (is_bne && !operands_eq);
   assign act_target  = is_j ? j_target : br_target;

   // wrong direction, or right direction but stale target
   assign mispred = (act_taken != ex_pred_taken) ||
                    (act_taken && (act_target != ex_pred_target));

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         flush   <= 1'b0;
         upd_wen <= 1'b0;
      end else begin
         flush   <= resolve && mispred;
         upd_wen <= resolve;
      end
   end

   // payload only meaningful while the strobes are high
   always_ff @(posedge CLK) begin
      if (resolve) begin
         redirect_pc <= act_taken ? act_target : pc_plus4;
         upd_pc      <= ex_pc;
         upd_taken   <= act_taken;
         upd_target  <= act_target;
      end
   end

   // fetch loads this straight into pc
   a_redirect_aligned: assert property (@(posedge CLK) disable iff (!nRST)
      flush |-> (redirect_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== design/btb.sv ====
/*
 * branch target buffer
 * direct-mapped, full PC tag, target and 2-bit counter per entry;
 * combinational lookup, update or allocate on the write strobe
 */
`timescale 1ns/1ns
`default_nettype none

module btb #(
   parameter int BTB_ENTRIES = 4
) (
   input  wire logic                 CLK,
   input  wire logic                 nRST,
   input  wire cpu_types_pkg::word_t rd_pc,
   input  wire logic                 wr_en,
   input  wire cpu_types_pkg::word_t wr_pc,
   input  wire logic                 wr_taken,
   input  wire cpu_types_pkg::word_t wr_target,
   output logic                      hit,
   output logic                      pred_taken,
   output cpu_types_pkg::word_t      pred_target
);
   import cpu_types_pkg::*;
   import btb_pkg::*;

   localparam int IDX_W = $clog2(BTB_ENTRIES);

   logic [BTB_ENTRIES-1:0] ent_valid;
   word_t                  ent_pc     [BTB_ENTRIES];
   word_t                  ent_target [BTB_ENTRIES];
   pred_state_t            ent_state  [BTB_ENTRIES];

   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W-1:0] wr_idx;
   logic             wr_match;

   // saturating step toward the resolved outcome
   function automatic pred_state_t next_state(input pred_state_t cur, input logic taken);
      case (cur)
         STRONG_TAKEN:     next_state = taken ? STRONG_TAKEN : WEAK_TAKEN;
         WEAK_TAKEN:       next_state = taken ? STRONG_TAKEN : WEAK_NOT_TAKEN;
         WEAK_NOT_TAKEN:   next_state = taken ? WEAK_TAKEN : STRONG_NOT_TAKEN;
         default:          next_state = taken ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
      endcase
   endfunction

   // word index, byte offset bits dropped
   assign rd_idx = rd_pc[IDX_W+1:2];
   assign wr_idx = wr_pc[IDX_W+1:2];

   // lookup
   assign hit         = ent_valid[rd_idx] && (ent_pc[rd_idx] == rd_pc);
   assign pred_taken  = hit && ent_state[rd_idx][1];
   assign pred_target = hit ? ent_target[rd_idx] : '0;

   // same branch already resident, only train its counter
   assign wr_match = ent_valid[wr_idx] && (ent_pc[wr_idx] == wr_pc);

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         ent_valid <= '0;
      end else if (wr_en) begin
         ent_valid[wr_idx] <= 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (wr_en) begin
         if (wr_match) begin
            ent_state[wr_idx] <= next_state(ent_state[wr_idx], wr_taken);
         end else begin
            // new branch or alias, evict whatever was there
            ent_pc[wr_idx]     <= wr_pc;
            ent_target[wr_idx] <= wr_target;
            ent_state[wr_idx]  <= PRED_ALLOC_STATE;
         end
      end
   end

   // resolver must only ever hand us instruction addresses
   a_wr_pc_aligned: assert property (@(posedge CLK) disable iff (!nRST)
      wr_en |-> (wr_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== design/btb_pkg.sv ====
/*
 * branch predictor types
 * 2-bit saturating counter states and the state given to a new entry
 */
`default_nettype none

package btb_pkg;

   // msb set means the entry predicts taken
   typedef enum logic [1:0] {
      STRONG_NOT_TAKEN = 2'b00,
      WEAK_NOT_TAKEN   = 2'b01,
      WEAK_TAKEN       = 2'b10,
      STRONG_TAKEN     = 2'b11
   } pred_state_t;

   // freshly allocated entries lean taken
   parameter pred_state_t PRED_ALLOC_STATE = WEAK_TAKEN;

endpackage

`default_nettype wire

// ==== design/cpu_types_pkg.sv ====
/*
 * cpu types
 * ISA-level types shared by the branch prediction front end:
 * data word, opcodes and the I-type / J-type instruction views
 */
`default_nettype none

package cpu_types_pkg;

   parameter int WORD_W = 32;

   typedef logic [WORD_W-1:0] word_t;

   // primary opcode field, MIPS encodings
   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      J     = 6'b000010,
      JAL   = 6'b000011,
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ADDI  = 6'b001000,
      LW    = 6'b100011,
      SW    = 6'b101011
   } opcode_t;

   // conditional branches and immediates
   typedef struct packed {
      opcode_t     opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } itype_t;

   // absolute jumps
   typedef struct packed {
      opcode_t     opcode;
      logic [25:0] addr;
   } jtype_t;

   // same instruction word, read either way by the resolver
   typedef union packed {
      itype_t i;
      jtype_t j;
   } instr_t;

endpackage

`default_nettype wire

// ==== design/fetch_pc.sv ====
/*
 * fetch program counter
 * next address priority: redirect, stall hold, predicted target, pc + 4
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_pc #(
   parameter cpu_types_pkg::word_t RESET_PC = '0
) (
   input  wire logic                 CLK,
   input  wire logic                 nRST,
   input  wire logic                 stall,
   input  wire logic                 flush,
   input  wire cpu_types_pkg::word_t redirect_pc,
   input  wire logic                 btb_hit,
   input  wire logic                 btb_taken,
   input  wire cpu_types_pkg::word_t btb_target,
   output cpu_types_pkg::word_t      pc
);
   import cpu_types_pkg::*;

   word_t next_pc;

   always_comb begin
      if (flush) begin
         // a redirect wins even over a stalled front end
         next_pc = redirect_pc;
      end else if (stall) begin
         next_pc = pc;
      end else if (btb_hit && btb_taken) begin
         next_pc = btb_target;
      end else begin
         next_pc = pc + 32'd4;
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         pc <= RESET_PC;
      end else begin
         pc <= next_pc;
      end
   end

   a_pc_aligned: assert property (@(posedge CLK) disable iff (!nRST)
      pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== filelist.f ====
design/cpu_types_pkg.sv
design/btb_pkg.sv
design/btb.sv
design/branch_resolve.sv
design/fetch_pc.sv
design/bpred_top.sv
sim/bpred_tb.sv

// ==== sim/bpred_tb.sv ====
/*
 * branch prediction front end testbench
 * directed tests checked against a reference BTB table kept beside the DUT
 */
`timescale 1ns/1ns
`default_nettype none

module bpred_tb;
   import cpu_types_pkg::*;
   import btb_pkg::*;

   localparam int    BTB_ENTRIES = 4;
   localparam word_t RESET_PC    = 32'h0000_0000;
   // 16 resolutions of 2 cycles, the fetch test and reset stay under 50 cycles
   localparam int    TEST_CYCLES = 50;
   localparam int    MAX_CYCLES  = 8 * TEST_CYCLES;

   // branch X with its backward target, an alias Y of X, a far jump and the steering jump
   localparam word_t X_PC     = 32'h0000_0040;
   localparam word_t X_TARGET = 32'h0000_0020;
   localparam word_t Y_PC     = 32'h0000_0050;
   localparam word_t Y_TARGET = 32'h0000_0044;
   localparam word_t J_PC     = 32'h3000_0108;
   localparam word_t J_TARGET = 32'h3000_00C0;
   localparam word_t STEER_PC = 32'h0000_0204;

   logic   CLK;
   logic   nRST;
   logic   stall;
   logic   ex_valid;
   word_t  ex_pc;
   instr_t ex_instr;
   word_t  ex_rs_data;
   word_t  ex_rt_data;
   logic   ex_pred_taken;
   word_t  ex_pred_target;
   word_t  pc;
   logic   pred_taken;
   word_t  pred_target;
   logic   flush;
   word_t  redirect_pc;

   // reference predictor table
   logic        ref_valid  [BTB_ENTRIES];
   word_t       ref_pc     [BTB_ENTRIES];
   word_t       ref_target [BTB_ENTRIES];
   pred_state_t ref_state  [BTB_ENTRIES];

   int    cycles;
   int    errors;
   int    errors_at_start;
   int    tests_run;
   int    tests_failed;
   string cur_test;

   bpred_top #(
      .BTB_ENTRIES (BTB_ENTRIES),
      .RESET_PC    (RESET_PC)
   ) dut0 (.*);

   always #4 CLK = ~CLK;

   always @(posedge CLK) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic check_word(input string what, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("ERROR %s %s: expected %h, actual %h", cur_test, what, expected, actual);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      errors_at_start = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors != errors_at_start) begin
         tests_failed++;
         $display("test %s: FAIL, %0d errors", cur_test, errors - errors_at_start);
      end else begin
         $display("test %s: pass", cur_test);
      end
   endtask

   function automatic int index_of(input word_t a);
      return int'((a >> 2) % word_t'(BTB_ENTRIES));
   endfunction

   // saturating step, STRONG_NOT_TAKEN is 0 and STRONG_TAKEN is 3
   function automatic pred_state_t train_counter(input pred_state_t s, input logic taken);
      if (taken && s != STRONG_TAKEN)
         return pred_state_t'(s + 2'd1);
      if (!taken && s != STRONG_NOT_TAKEN)
         return pred_state_t'(s - 2'd1);
      return s;
   endfunction

   task automatic model_update(input word_t a, input logic taken, input word_t target);
      int k;
      k = index_of(a);
      if (ref_valid[k] && ref_pc[k] == a) begin
         ref_state[k] = train_counter(ref_state[k], taken);
      end else begin
         ref_valid[k]  = 1'b1;
         ref_pc[k]     = a;
         ref_target[k] = target;
         ref_state[k]  = WEAK_TAKEN;
      end
   endtask

   function automatic instr_t make_branch(input opcode_t op, input logic [15:0] imm);
      instr_t w;
      w.i.opcode = op;
      w.i.rs     = 5'd1;
      w.i.rt     = 5'd2;
      w.i.imm    = imm;
      return w;
   endfunction

   function automatic instr_t make_jump(input logic [25:0] addr);
      instr_t w;
      w.j.opcode = J;
      w.j.addr   = addr;
      return w;
   endfunction

   // flush and redirect follow one edge after ex_valid, the corrected pc one edge later
   task automatic resolve_check(input word_t at_pc, input instr_t instr,
                                input word_t rs, input word_t rt,
                                input logic p_taken, input word_t p_target,
                                input logic ctrl, input logic a_taken, input word_t a_target);
      logic  exp_flush;
      word_t exp_redirect;
      exp_flush    = ctrl && ((a_taken != p_taken) || (a_taken && a_target != p_target));
      exp_redirect = a_taken ? a_target : at_pc + 32'd4;
      ex_valid       = 1'b1;
      ex_pc          = at_pc;
      ex_instr       = instr;
      ex_rs_data     = rs;
      ex_rt_data     = rt;
      ex_pred_taken  = p_taken;
      ex_pred_target = p_target;
      @(posedge CLK);
      @(negedge CLK);
      ex_valid = 1'b0;
      check_word("flush", 32'(exp_flush), 32'(flush));
      if (exp_flush)
         check_word("redirect_pc", exp_redirect, redirect_pc);
      if (ctrl)
         model_update(at_pc, a_taken, a_target);
      @(negedge CLK);
      check_word("flush pulse end", 32'd0, 32'(flush));
      if (exp_flush)
         check_word("pc after redirect", exp_redirect, pc);
   endtask

   // a mispredicted jump from a spare address puts fetch at the given pc
   task automatic steer_fetch(input word_t target);
      resolve_check(STEER_PC, make_jump(target[27:2]), '0, '0, 1'b0, '0, 1'b1, 1'b1, target);
   endtask

   task automatic check_prediction(input word_t at_pc);
      int   k;
      logic hit;
      k   = index_of(at_pc);
      hit = ref_valid[k] && (ref_pc[k] == at_pc);
      check_word("pred_taken", 32'(hit && ref_state[k][1]), 32'(pred_taken));
      check_word("pred_target", hit ? ref_target[k] : '0, pred_target);
   endtask

   task automatic reset_and_fetch();
      word_t held;
      int    n;
      start_test("reset_and_fetch");
      check_word("pc after reset", RESET_PC, pc);
      check_word("flush after reset", 32'd0, 32'(flush));
      for (n = 1; n <= 4; n++) begin
         @(negedge CLK);
         check_word("sequential pc", RESET_PC + 32'(4 * n), pc);
      end
      stall = 1'b1;
      held  = pc;
      repeat (3) begin
         @(negedge CLK);
         check_word("stalled pc", held, pc);
      end
      stall = 1'b0;
      finish_test();
   endtask

   task automatic cold_taken_branch();
      start_test("cold_taken_branch");
      resolve_check(X_PC, make_branch(BEQ, 16'hFFF7), 32'd7, 32'd7,
                    1'b0, '0, 1'b1, 1'b1, X_TARGET);
      steer_fetch(X_PC);
      check_prediction(X_PC);
      finish_test();
   endtask

   task automatic counter_hysteresis();
      start_test("counter_hysteresis");
      // BNE on equal operands falls through, twice
      resolve_check(X_PC, make_branch(BNE, 16'hFFF7), 32'd3, 32'd3,
                    1'b1, X_TARGET, 1'b1, 1'b0, X_TARGET);
      steer_fetch(X_PC);
      check_prediction(X_PC);
      resolve_check(X_PC, make_branch(BNE, 16'hFFF7), 32'd3, 32'd3,
                    1'b0, X_TARGET, 1'b1, 1'b0, X_TARGET);
      steer_fetch(X_PC);
      check_prediction(X_PC);
      // a single taken outcome is not enough to flip it back
      resolve_check(X_PC, make_branch(BEQ, 16'hFFF7), 32'd3, 32'd3,
                    1'b0, X_TARGET, 1'b1, 1'b1, X_TARGET);
      steer_fetch(X_PC);
      check_prediction(X_PC);
      finish_test();
   endtask

   task automatic jump_target();
      start_test("jump_target");
      // the redirect still lands while fetch is stalled
      stall = 1'b1;
      resolve_check(J_PC, make_jump(26'h30), '0, '0, 1'b1, J_TARGET + 32'd4,
                    1'b1, 1'b1, J_TARGET);
      stall = 1'b0;
      resolve_check(J_PC, make_jump(26'h30), '0, '0, 1'b1, J_TARGET, 1'b1, 1'b1, J_TARGET);
      finish_test();
   endtask

   task automatic index_aliasing();
      start_test("index_aliasing");
      resolve_check(Y_PC, make_branch(BEQ, 16'hFFFC), 32'd9, 32'd9,
                    1'b0, '0, 1'b1, 1'b1, Y_TARGET);
      steer_fetch(X_PC);
      check_prediction(X_PC);
      // X comes back through a not-taken resolution and starts over
      resolve_check(X_PC, make_branch(BEQ, 16'hFFF7), 32'd1, 32'd2,
                    1'b0, '0, 1'b1, 1'b0, X_TARGET);
      steer_fetch(X_PC);
      check_prediction(X_PC);
      finish_test();
   endtask

   task automatic ignored_opcode();
      start_test("ignored_opcode");
      resolve_check(X_PC, make_branch(ADDI, 16'hFFF7), 32'd4, 32'd4,
                    1'b1, 32'h0000_0100, 1'b0, 1'b0, '0);
      steer_fetch(X_PC);
      check_prediction(X_PC);
      finish_test();
   endtask

   initial begin
      int i;
      CLK            = 1'b0;
      nRST           = 1'b0;
      stall          = 1'b0;
      ex_valid       = 1'b0;
      ex_pc          = '0;
      ex_instr       = '0;
      ex_rs_data     = '0;
      ex_rt_data     = '0;
      ex_pred_taken  = 1'b0;
      ex_pred_target = '0;
      cycles         = 0;
      errors         = 0;
      tests_run      = 0;
      tests_failed   = 0;
      for (i = 0; i < BTB_ENTRIES; i++)
         ref_valid[i] = 1'b0;
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;
      reset_and_fetch();
      cold_taken_branch();
      counter_hysteresis();
      jump_target();
      index_aliasing();
      ignored_opcode();
      $display("tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
